// File: pipeCtrl_settings.svh
`ifndef PIPECTRL_SETTINGS_SVH
`define PIPECTRL_SETTINGS_SVH

// architectural register address, 32 GPRs
`define REG_ADDR_W 5

// operand and result word
`define DATA_W 32

`endif

// File: pipeCtrl_pkg.sv
package pipeCtrl_pkg;

    // stages past decode that carry a destination: E, M, M2, W
    localparam int TRACK_STAGES = 4;

    // tracker slot of each stage
    localparam int SLOT_E  = 0;
    localparam int SLOT_M  = 1;
    localparam int SLOT_M2 = 2;
    localparam int SLOT_W  = 3;

    // where a decode operand comes from
    // encodings match the existing core, higher value = younger stage
    typedef enum logic [2:0] {
        fwdNone = 3'd0, // register file
        fwdW    = 3'd1,
        fwdM2   = 3'd2,
        fwdM    = 3'd3,
        fwdE    = 3'd4
    } fwdSel_e;

endpackage

// File: hazardUnit.sv
`timescale 1ns/100ps
`include "pipeCtrl_settings.svh"

module hazardUnit import pipeCtrl_pkg::*; (
    input  logic                   iCacheStall,
    input  logic                   dCacheStall,
    input  logic                   aluStallE,
    input  logic                   blankSl,     // store-load spacing request
    input  logic                   flushJumpConflictE,
    input  logic                   flushPredFailedM,
    input  logic                   flushExceptionM,
    input  logic                   jumpD,
    input  logic                   branchD,
    input  logic                   branchM,
    input  logic                   predRight,
    input  logic                   predTakeD,
    input  logic [`REG_ADDR_W-1:0] rsD,
    input  logic [`REG_ADDR_W-1:0] rtD,
    input  logic                   regWriteE,
    input  logic                   regWriteM,
    input  logic                   regWriteM2,
    input  logic                   regWriteW,
    input  logic [`REG_ADDR_W-1:0] writeRegE,
    input  logic [`REG_ADDR_W-1:0] writeRegM,
    input  logic [`REG_ADDR_W-1:0] writeRegM2,
    input  logic [`REG_ADDR_W-1:0] writeRegW,
    input  logic                   memReadE,
    input  logic                   memReadM,
    input  logic                   isMfcE,
    output logic                   stallF,
    output logic                   stallF2,
    output logic                   stallD,
    output logic                   stallE,
    output logic                   stallM,
    output logic                   stallM2,
    output logic                   stallW,
    output logic                   flushF2,
    output logic                   flushD,
    output logic                   flushE,
    output logic                   flushM,
    output logic                   flushM2,
    output logic                   longestStall,
    output logic                   stallDBlank,
    output logic                   iCacheCtl,
    output fwdSel_e                fwd1D,
    output fwdSel_e                fwd2D
);

    logic cacheStall;
    logic branchOk;
    logic useE;  // an operand wants the E result
    logic useM;  // an operand wants the M result

    // youngest writer of src wins, r0 is hardwired and never forwards
    function automatic fwdSel_e pickSource(input logic [`REG_ADDR_W-1:0] src);
        fwdSel_e sel;
        sel = fwdNone;
        if (src != '0) begin
            if (regWriteE && src == writeRegE)
                sel = fwdE;
            else if (regWriteM && src == writeRegM)
                sel = fwdM;
            else if (regWriteM2 && src == writeRegM2)
                sel = fwdM2;
            else if (regWriteW && src == writeRegW)
                sel = fwdW;
        end
        return sel;
    endfunction

    always_comb begin
        fwd1D = pickSource(rsD);
        fwd2D = pickSource(rtD);
    end

    assign useE = (fwd1D == fwdE) || (fwd2D == fwdE);
    assign useM = (fwd1D == fwdM) || (fwd2D == fwdM);

    // load or mfc0 data is not ready in E, load data not ready in M either
    assign stallDBlank = (useE && (memReadE || isMfcE)) || (useM && memReadM);

    assign cacheStall   = iCacheStall | dCacheStall;
    assign longestStall = cacheStall | aluStallE;
    assign iCacheCtl    = dCacheStall | aluStallE | stallDBlank | blankSl;

    // taken prediction at D is only acted on when M is not about to redirect
    assign branchOk = (~branchM | (branchM & predRight)) & branchD & predTakeD;

    // front end holds on everything, back end tiers drop sources
    assign stallF  = ~flushExceptionM & (longestStall | stallDBlank | blankSl);
    assign stallF2 = longestStall | stallDBlank | blankSl;
    assign stallD  = longestStall | stallDBlank | blankSl;
    assign stallE  = longestStall | blankSl;
    assign stallM  = longestStall | blankSl;
    assign stallM2 = longestStall;
    assign stallW  = ~flushExceptionM & longestStall;

    assign flushF2 = flushExceptionM | flushPredFailedM
                   | ((flushJumpConflictE | jumpD | branchOk) & ~stallF2);
    assign flushD  = flushExceptionM | flushPredFailedM | (flushJumpConflictE & ~stallD);
    assign flushE  = flushExceptionM | (flushPredFailedM & ~longestStall)
                   | (stallDBlank & ~stallE);                 // bubble behind a held D
    assign flushM  = flushExceptionM;
    assign flushM2 = flushExceptionM | (blankSl & ~stallM2);  // gap between store and load

endmodule

// File: destTracker.sv
`timescale 1ns/100ps
`include "pipeCtrl_settings.svh"

module destTracker import pipeCtrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   regWriteD,
    input  logic [`REG_ADDR_W-1:0] writeRegD,
    input  logic                   memReadD,
    input  logic                   isMfcD,
    input  logic                   stallE,
    input  logic                   stallM,
    input  logic                   stallM2,
    input  logic                   stallW,
    input  logic                   flushE,
    input  logic                   flushM,
    input  logic                   flushM2,
    output logic                   regWriteE,
    output logic                   regWriteM,
    output logic                   regWriteM2,
    output logic                   regWriteW,
    output logic [`REG_ADDR_W-1:0] writeRegE,
    output logic [`REG_ADDR_W-1:0] writeRegM,
    output logic [`REG_ADDR_W-1:0] writeRegM2,
    output logic [`REG_ADDR_W-1:0] writeRegW,
    output logic                   memReadE,
    output logic                   memReadM,
    output logic                   isMfcE
);

    logic [TRACK_STAGES-1:0]  stallVec;
    logic [TRACK_STAGES-1:0]  flushVec;
    logic [TRACK_STAGES-1:0]  regWriteIn;
    logic [TRACK_STAGES-1:0]  regWriteQ;
    logic [`REG_ADDR_W-1:0]   writeRegIn [TRACK_STAGES];
    logic [`REG_ADDR_W-1:0]   writeRegQ  [TRACK_STAGES];
    logic [SLOT_M:SLOT_E]     memReadQ;   // load flag is only needed up to M

    // W is never flushed by the hazard unit
    assign stallVec = {stallW, stallM2, stallM, stallE};
    assign flushVec = {1'b0, flushM2, flushM, flushE};

    // each slot is fed by the one before it, slot E by decode
    assign regWriteIn = {regWriteQ[TRACK_STAGES-2:0], regWriteD};
    assign writeRegIn[SLOT_E] = writeRegD;

    for (genvar s = 0; s < TRACK_STAGES; s++) begin : gStage
        if (s > 0) begin : gFeed
            assign writeRegIn[s] = writeRegQ[s-1];
        end

        always_ff @(posedge clk) begin
            if (!rstN || flushVec[s]) begin    // flush beats stall
                regWriteQ[s] <= 1'b0;
                writeRegQ[s] <= '0;
            end else if (!stallVec[s]) begin
                regWriteQ[s] <= regWriteIn[s];
                writeRegQ[s] <= writeRegIn[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || flushE) begin
            memReadQ[SLOT_E] <= 1'b0;
            isMfcE           <= 1'b0;
        end else if (!stallE) begin
            memReadQ[SLOT_E] <= memReadD;
            isMfcE           <= isMfcD;   // mfc0 result appears late, like a load
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || flushM)
            memReadQ[SLOT_M] <= 1'b0;
        else if (!stallM)
            memReadQ[SLOT_M] <= memReadQ[SLOT_E];
    end

    assign regWriteE  = regWriteQ[SLOT_E];
    assign regWriteM  = regWriteQ[SLOT_M];
    assign regWriteM2 = regWriteQ[SLOT_M2];
    assign regWriteW  = regWriteQ[SLOT_W];
    assign writeRegE  = writeRegQ[SLOT_E];
    assign writeRegM  = writeRegQ[SLOT_M];
    assign writeRegM2 = writeRegQ[SLOT_M2];
    assign writeRegW  = writeRegQ[SLOT_W];
    assign memReadE   = memReadQ[SLOT_E];
    assign memReadM   = memReadQ[SLOT_M];

endmodule

// File: operandForward.sv
`timescale 1ns/100ps
`include "pipeCtrl_settings.svh"

module operandForward import pipeCtrl_pkg::*; (
    input  fwdSel_e              fwd1D,
    input  fwdSel_e              fwd2D,
    input  logic [`DATA_W-1:0]   rsDataD,   // register file port 1
    input  logic [`DATA_W-1:0]   rtDataD,   // register file port 2
    input  logic [`DATA_W-1:0]   resultE,
    input  logic [`DATA_W-1:0]   resultM,
    input  logic [`DATA_W-1:0]   resultM2,
    input  logic [`DATA_W-1:0]   resultW,
    output logic [`DATA_W-1:0]   operand1D,
    output logic [`DATA_W-1:0]   operand2D
);

    // bypass mux for one operand
    // stage results are taken as arguments so the caller sees every input
    function automatic logic [`DATA_W-1:0] bypass(
        input fwdSel_e            sel,
        input logic [`DATA_W-1:0] rfData,
        input logic [`DATA_W-1:0] resE,
        input logic [`DATA_W-1:0] resM,
        input logic [`DATA_W-1:0] resM2,
        input logic [`DATA_W-1:0] resW
    );
        logic [`DATA_W-1:0] val;
        case (sel)
            fwdE:    val = resE;
            fwdM:    val = resM;
            fwdM2:   val = resM2;
            fwdW:    val = resW;
            default: val = rfData;   // fwdNone and unused codes
        endcase
        return val;
    endfunction

    always_comb begin
        operand1D = bypass(fwd1D, rsDataD, resultE, resultM, resultM2, resultW);
        operand2D = bypass(fwd2D, rtDataD, resultE, resultM, resultM2, resultW);
    end

endmodule

// File: pipeCtrlTop.sv
`timescale 1ns/100ps
`include "pipeCtrl_settings.svh"

module pipeCtrlTop import pipeCtrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`REG_ADDR_W-1:0] rsD,
    input  logic [`REG_ADDR_W-1:0] rtD,
    input  logic                   regWriteD,
    input  logic [`REG_ADDR_W-1:0] writeRegD,
    input  logic                   memReadD,
    input  logic                   isMfcD,
    input  logic [`DATA_W-1:0]     rsDataD,
    input  logic [`DATA_W-1:0]     rtDataD,
    input  logic                   iCacheStall,
    input  logic                   dCacheStall,
    input  logic                   aluStallE,
    input  logic                   flushJumpConflictE,
    input  logic                   flushPredFailedM,
    input  logic                   flushExceptionM,
    input  logic                   jumpD,
    input  logic                   branchD,
    input  logic                   branchM,
    input  logic                   predRight,
    input  logic                   predTakeD,
    input  logic                   blankSl,
    input  logic [`DATA_W-1:0]     resultE,
    input  logic [`DATA_W-1:0]     resultM,
    input  logic [`DATA_W-1:0]     resultM2,
    input  logic [`DATA_W-1:0]     resultW,
    output logic                   stallF, stallF2, stallD, stallE, stallM, stallM2, stallW,
    output logic                   flushF2, flushD, flushE, flushM, flushM2,
    output logic                   longestStall,
    output logic                   stallDBlank,
    output logic                   iCacheCtl,
    output fwdSel_e                fwd1D,
    output fwdSel_e                fwd2D,
    output logic [`DATA_W-1:0]     operand1D,
    output logic [`DATA_W-1:0]     operand2D
);

    // in-flight destinations, tracker to hazard unit
    logic                   regWriteE, regWriteM, regWriteM2, regWriteW;
    logic [`REG_ADDR_W-1:0] writeRegE, writeRegM, writeRegM2, writeRegW;
    logic                   memReadE, memReadM, isMfcE;

    destTracker u_destTracker (
        .clk, .rstN, .regWriteD, .writeRegD, .memReadD, .isMfcD,
        .stallE, .stallM, .stallM2, .stallW, .flushE, .flushM, .flushM2,
        .regWriteE, .regWriteM, .regWriteM2, .regWriteW,
        .writeRegE, .writeRegM, .writeRegM2, .writeRegW,
        .memReadE, .memReadM, .isMfcE
    );

    hazardUnit u_hazardUnit (
        .iCacheStall, .dCacheStall, .aluStallE, .blankSl,
        .flushJumpConflictE, .flushPredFailedM, .flushExceptionM,
        .jumpD, .branchD, .branchM, .predRight, .predTakeD, .rsD, .rtD,
        .regWriteE, .regWriteM, .regWriteM2, .regWriteW,
        .writeRegE, .writeRegM, .writeRegM2, .writeRegW,
        .memReadE, .memReadM, .isMfcE,
        .stallF, .stallF2, .stallD, .stallE, .stallM, .stallM2, .stallW,
        .flushF2, .flushD, .flushE, .flushM, .flushM2,
        .longestStall, .stallDBlank, .iCacheCtl, .fwd1D, .fwd2D
    );

    operandForward u_operandForward (
        .fwd1D, .fwd2D, .rsDataD, .rtDataD,
        .resultE, .resultM, .resultM2, .resultW,
        .operand1D, .operand2D
    );

endmodule

// File: tb_pipeCtrl.sv
`timescale 1ns/100ps
`include "pipeCtrl_settings.svh"

module tb_pipeCtrl import pipeCtrl_pkg::*; ();

    localparam int AW = `REG_ADDR_W;
    localparam int DW = `DATA_W;
    localparam int CLK_PERIOD = 40;
    localparam logic [31:0] SEED = 32'h22be84b2;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    // cycles per test, the watchdog is derived from their sum
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES = 8;
    localparam int RAND_CYCLES = 400;
    localparam int LOAD_CYCLES = 12;
    localparam int TIER_CYCLES = 5;
    localparam int REDIRECT_CYCLES = 8;
    localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + RAND_CYCLES + LOAD_CYCLES
                                + TIER_CYCLES + REDIRECT_CYCLES;
    localparam int TIMEOUT_NS = TOTAL_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD;

    logic clk, rstN;
    logic [AW-1:0] rsD, rtD, writeRegD;
    logic regWriteD, memReadD, isMfcD;
    logic [DW-1:0] rsDataD, rtDataD, resultE, resultM, resultM2, resultW;
    logic iCacheStall, dCacheStall, aluStallE, blankSl;
    logic flushJumpConflictE, flushPredFailedM, flushExceptionM;
    logic jumpD, branchD, branchM, predRight, predTakeD;
    logic stallF, stallF2, stallD, stallE, stallM, stallM2, stallW;
    logic flushF2, flushD, flushE, flushM, flushM2;
    logic longestStall, stallDBlank, iCacheCtl;
    fwdSel_e fwd1D, fwd2D;
    logic [DW-1:0] operand1D, operand2D;

    // descriptor model of E, M, M2, W
    logic          mRegWrite [TRACK_STAGES];
    logic [AW-1:0] mWriteReg [TRACK_STAGES];
    logic          mMemReadE, mMemReadM, mIsMfcE;

    logic [AW-1:0] resetDest;   // destination held at D through reset

    logic [31:0] lfsr;
    int errCount, checkCount, testErrs, testCount;

    pipeCtrlTop u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
        end
        return v;
    endfunction

    // youngest in-flight writer of src, r0 never forwards
    function automatic fwdSel_e predictSource(input logic [AW-1:0] src);
        if (src == '0) return fwdNone;
        if (mRegWrite[SLOT_E] && mWriteReg[SLOT_E] == src) return fwdE;
        if (mRegWrite[SLOT_M] && mWriteReg[SLOT_M] == src) return fwdM;
        if (mRegWrite[SLOT_M2] && mWriteReg[SLOT_M2] == src) return fwdM2;
        if (mRegWrite[SLOT_W] && mWriteReg[SLOT_W] == src) return fwdW;
        return fwdNone;
    endfunction

    function automatic logic [DW-1:0] expectedOperand(input fwdSel_e sel,
                                                      input logic [DW-1:0] rfData);
        case (sel)
            fwdE:    return resultE;
            fwdM:    return resultM;
            fwdM2:   return resultM2;
            fwdW:    return resultW;
            default: return rfData;
        endcase
    endfunction

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        assert (got === exp) else begin
            errCount++;
            testErrs++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errCount++;
            testErrs++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic expectTrue(input logic cond, input string what);
        checkCount++;
        assert (cond === 1'b1) else begin
            errCount++;
            testErrs++;
            $display("%s at %0t", what, $time);
        end
    endtask

    task automatic idleInputs();
        rsD = '0;
        rtD = '0;
        writeRegD = '0;
        {regWriteD, memReadD, isMfcD} = '0;
        {iCacheStall, dCacheStall, aluStallE, blankSl} = '0;
        {flushJumpConflictE, flushPredFailedM, flushExceptionM} = '0;
        {jumpD, branchD, branchM, predRight, predTakeD} = '0;
    endtask

    task automatic randomInputs();
        rsD = AW'(randBits(3));        // narrow range so matches are common
        rtD = AW'(randBits(3));
        writeRegD = AW'(randBits(3));
        regWriteD = 1'(randBits(1));
        memReadD = (randBits(2) == 0);
        isMfcD = (randBits(3) == 0);
        iCacheStall = (randBits(3) == 0);
        dCacheStall = (randBits(4) == 0);
        aluStallE = (randBits(4) == 0);
        blankSl = (randBits(4) == 0);
        flushExceptionM = (randBits(5) == 0);
        flushPredFailedM = (randBits(5) == 0);
        flushJumpConflictE = (randBits(3) == 0);
        {jumpD, branchD, branchM, predRight, predTakeD} = 5'(randBits(5));
        rsDataD = randBits(DW);
        rtDataD = randBits(DW);
        resultE = randBits(DW);
        resultM = randBits(DW);
        resultM2 = randBits(DW);
        resultW = randBits(DW);
    endtask

    task automatic settle();
        #(CLK_PERIOD / 4);
    endtask

    // compare against the rules, then shift the model by the DUT's stalls and flushes
    task automatic checkAndAdvance();
        fwdSel_e e1, e2;
        logic blank, longest, front, back, brTaken;
        e1 = predictSource(rsD);
        e2 = predictSource(rtD);
        blank = ((e1 == fwdE || e2 == fwdE) && (mMemReadE || mIsMfcE))
              || ((e1 == fwdM || e2 == fwdM) && mMemReadM);
        longest = iCacheStall | dCacheStall | aluStallE;
        front = longest | blank | blankSl;
        back = longest | blankSl;
        brTaken = branchD & predTakeD & ~(branchM & ~predRight);
        checkWord("fwd1D", fwd1D, e1);
        checkWord("fwd2D", fwd2D, e2);
        checkWord("operand1D", operand1D, expectedOperand(e1, rsDataD));
        checkWord("operand2D", operand2D, expectedOperand(e2, rtDataD));
        checkBit("stallDBlank", stallDBlank, blank);
        checkBit("longestStall", longestStall, longest);
        checkBit("iCacheCtl", iCacheCtl, dCacheStall | aluStallE | blank | blankSl);
        checkBit("stallF", stallF, ~flushExceptionM & front);
        checkBit("stallF2", stallF2, front);
        checkBit("stallD", stallD, front);
        checkBit("stallE", stallE, back);
        checkBit("stallM", stallM, back);
        checkBit("stallM2", stallM2, longest);
        checkBit("stallW", stallW, ~flushExceptionM & longest);
        checkBit("flushF2", flushF2, flushExceptionM | flushPredFailedM
                 | ((flushJumpConflictE | jumpD | brTaken) & ~front));
        checkBit("flushD", flushD, flushExceptionM | flushPredFailedM
                 | (flushJumpConflictE & ~front));
        checkBit("flushE", flushE, flushExceptionM | (flushPredFailedM & ~longest)
                 | (blank & ~back));
        checkBit("flushM", flushM, flushExceptionM);
        checkBit("flushM2", flushM2, flushExceptionM | (blankSl & ~longest));
        // oldest stage first so each takes its predecessor's old value
        if (!stallW) begin
            mRegWrite[SLOT_W] = mRegWrite[SLOT_M2];
            mWriteReg[SLOT_W] = mWriteReg[SLOT_M2];
        end
        if (flushM2) begin
            mRegWrite[SLOT_M2] = 1'b0;
        end else if (!stallM2) begin
            mRegWrite[SLOT_M2] = mRegWrite[SLOT_M];
            mWriteReg[SLOT_M2] = mWriteReg[SLOT_M];
        end
        if (flushM) begin
            mRegWrite[SLOT_M] = 1'b0;
            mMemReadM = 1'b0;
        end else if (!stallM) begin
            mRegWrite[SLOT_M] = mRegWrite[SLOT_E];
            mWriteReg[SLOT_M] = mWriteReg[SLOT_E];
            mMemReadM = mMemReadE;
        end
        if (flushE) begin
            {mRegWrite[SLOT_E], mMemReadE, mIsMfcE} = '0;
        end else if (!stallE) begin
            mRegWrite[SLOT_E] = regWriteD;
            mWriteReg[SLOT_E] = writeRegD;
            {mMemReadE, mIsMfcE} = {memReadD, isMfcD};
        end
        @(negedge clk);
    endtask

    task automatic evaluate();
        settle();
        checkAndAdvance();
    endtask

    task automatic endTest(input string name);
        $display("test %s done, %0d errors", name, testErrs);
        testCount++;
        testErrs = 0;
    endtask

    initial begin
        lfsr = SEED;
        {errCount, checkCount, testErrs, testCount} = '0;
        for (int s = 0; s < TRACK_STAGES; s++) begin
            mRegWrite[s] = 1'b0;
            mWriteReg[s] = '0;
        end
        {mMemReadE, mMemReadM, mIsMfcE} = '0;
        rstN = 1'b0;
        idleInputs();
        resetDest = AW'(randBits(AW)) | AW'(1);
        // a load sits at D during reset and must not reach E
        {regWriteD, memReadD} = 2'b11;
        writeRegD = resetDest;
        {rsDataD, rtDataD} = '0;
        {resultE, resultM, resultM2, resultW} = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (int i = 0; i < IDLE_CYCLES; i++) begin
            idleInputs();
            rsD = AW'(randBits(AW));
            rtD = resetDest;
            settle();
            expectTrue(fwd1D == fwdNone && fwd2D == fwdNone && !stallDBlank,
                       "forwarding or decode stall active right after reset");
            checkAndAdvance();
        end
        endTest("reset");

        for (int i = 0; i < RAND_CYCLES; i++) begin
            randomInputs();
            evaluate();
        end
        endTest("forwarding");

        for (int i = 0; i < 5; i++) begin   // drain the pipeline
            idleInputs();
            evaluate();
        end
        idleInputs();
        {regWriteD, memReadD} = 2'b11;
        writeRegD = AW'(5);
        evaluate();
        idleInputs();
        rsD = AW'(5);
        settle();
        expectTrue(stallD && flushE && !stallE, "load at E did not hold decode over a bubble");
        checkAndAdvance();
        idleInputs();
        rsD = AW'(5);
        settle();
        expectTrue(stallD && fwd1D == fwdM, "load at M did not keep decode stalled");
        checkAndAdvance();
        idleInputs();
        rsD = AW'(5);
        settle();
        expectTrue(!stallD && fwd1D == fwdM2, "load at M2 still stalls decode");
        checkAndAdvance();
        idleInputs();
        {regWriteD, isMfcD} = 2'b11;
        writeRegD = AW'(7);
        evaluate();
        idleInputs();
        rtD = AW'(7);
        settle();
        expectTrue(stallD && flushE && !stallE, "mfc0 at E did not hold decode over a bubble");
        checkAndAdvance();
        idleInputs();
        rtD = AW'(7);
        settle();
        expectTrue(!stallDBlank && fwd2D == fwdM, "mfc0 at M still stalls decode");
        checkAndAdvance();
        endTest("load-use");

        for (int k = 0; k < TIER_CYCLES; k++) begin
            idleInputs();
            case (k)
                0: iCacheStall = 1'b1;
                1: dCacheStall = 1'b1;
                2: aluStallE = 1'b1;
                3: blankSl = 1'b1;
                default: {iCacheStall, flushExceptionM} = 2'b11;  // exception masks F and W
            endcase
            evaluate();
        end
        endTest("tiers");

        for (int k = 0; k < REDIRECT_CYCLES; k++) begin
            idleInputs();
            case (k)
                0: flushExceptionM = 1'b1;
                1: flushPredFailedM = 1'b1;
                2: {flushPredFailedM, aluStallE} = 2'b11;
                3: flushJumpConflictE = 1'b1;
                4: jumpD = 1'b1;
                5: {branchD, predTakeD} = 2'b11;
                6: {branchD, predTakeD, branchM} = 3'b111;           // M mispredicts
                default: {branchD, predTakeD, branchM, predRight} = 4'hf;
            endcase
            evaluate();
        end
        endTest("redirects");

        $display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: pipeCtrl.f
+incdir+.
pipeCtrl_pkg.sv
hazardUnit.sv
destTracker.sv
operandForward.sv
pipeCtrlTop.sv
tb_pipeCtrl.sv

// File: Bender.yml
package:
  name: pipeCtrl

sources:
  - include_dirs:
      - .
    files:
      - pipeCtrl_pkg.sv
      - hazardUnit.sv
      - destTracker.sv
      - operandForward.sv
      - pipeCtrlTop.sv
      - target: simulation
        files:
          - tb_pipeCtrl.sv
